// File: logic/cart_pkg.sv
// Cartridge download types
package cart_pkg;

	// ========================================
	// Download bus
	// ========================================

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} ioctl_t;

	// Active download, at most one flag set
	typedef struct packed {
		logic cart;
		logic code;
		logic spc;
	} dl_kind_t;

	// Download index values
	localparam logic [5:0] IDX_CART = 6'h01;
	localparam logic [5:0] IDX_SPC  = 6'h04;
	localparam logic [7:0] IDX_CODE = 8'hFF;

	// ========================================
	// Cartridge header
	// ========================================

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic [3:0]  ram_size;
	} cart_info_t;

	typedef enum logic [2:0] {
		AUTO,
		NO_HEADER,
		LOROM,
		HIROM,
		EXHIROM
	} header_mode_e;

	// Copier header sits in front of the image
	localparam logic [24:0] COPIER_HDR  = 25'd512;
	localparam logic [24:0] LOROM_HDR   = 25'h7FD6;
	localparam logic [24:0] HIROM_HDR   = 25'hFFD6;
	localparam logic [24:0] EXHIROM_HDR = 25'h40FFD6;

	localparam logic [3:0] DEF_ROM_SIZE = 4'hC;

	// Cheat record, one 32-bit field per word pair
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// File: logic/sys_pkg.sv
// System support types
package sys_pkg;

	// ========================================
	// Memory clearing
	// ========================================

	// Power-on RAM contents to imitate
	typedef enum logic [1:0] {
		SNES2_9966,
		SNES1_00FF,
		FILL_55,
		FILL_FF
	} fill_pattern_e;

	typedef struct packed {
		logic [17:0] addr;
		logic [7:0]  wram_data;
		logic [7:0]  aram_data;
		logic        we;
	} fill_t;

	localparam logic [7:0] BYTE_66 = 8'h66;
	localparam logic [7:0] BYTE_99 = 8'h99;
	localparam logic [7:0] BYTE_55 = 8'h55;
	localparam logic [7:0] BYTE_FF = 8'hFF;

	// ========================================
	// Audio
	// ========================================

	typedef struct packed {
		logic signed [15:0] l;
		logic signed [15:0] r;
	} stereo_t;

	// Saturation limits of a 16-bit sample
	localparam logic signed [15:0] SAMPLE_MAX = 16'sh7FFF;
	localparam logic signed [15:0] SAMPLE_MIN = 16'sh8000;

endpackage

// File: logic/download_decode.sv
// Download classifier and core reset
`timescale 1ns/100ps

module download_decode (
	input  logic               clk_sys,
	input  logic               RESET,
	input  cart_pkg::ioctl_t   ioctl,
	input  logic               clearing,
	output cart_pkg::dl_kind_t dl_kind,
	output logic               cart_start,
	output logic               core_reset
);

	logic cart_prev;

	// Index decode, only while a download is running
	always_comb begin
		dl_kind.cart = ioctl.download &
			((ioctl.index[5:0] == cart_pkg::IDX_CART) || (ioctl.index == 8'h00));
		dl_kind.spc  = ioctl.download & (ioctl.index[5:0] == cart_pkg::IDX_SPC);
		dl_kind.code = ioctl.download & (ioctl.index == cart_pkg::IDX_CODE);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_prev  <= 1'b0;
			cart_start <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			cart_prev  <= dl_kind.cart;
			// Rising edge of the cartridge flag
			cart_start <= dl_kind.cart & ~cart_prev;
			core_reset <= dl_kind.cart | dl_kind.spc | clearing;
		end
	end

	// Index stays steady for the whole download
	a_index_stable: assert property (
		@(posedge clk_sys) disable iff (RESET)
		ioctl.download |=> !ioctl.download || $stable(ioctl.index)
	);

endmodule

// File: logic/header_detect.sv
// Cartridge header detection
`timescale 1ns/100ps

module header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_pkg::ioctl_t       ioctl,
	input  cart_pkg::dl_kind_t     dl_kind,
	input  cart_pkg::header_mode_e header_mode,
	input  logic [1:0]             region_sel,
	output cart_pkg::cart_info_t   cart_info,
	output logic                   pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        rom_region;
	logic        size_valid;
	logic [24:0] hdr_base;
	logic        use_hdr;
	logic        cart_wr;

	assign cart_wr = dl_kind.cart & ioctl.wr;

	// Internal header location for forced modes
	always_comb begin
		case (header_mode)
			cart_pkg::LOROM:   hdr_base = cart_pkg::LOROM_HDR;
			cart_pkg::HIROM:   hdr_base = cart_pkg::HIROM_HDR;
			cart_pkg::EXHIROM: hdr_base = cart_pkg::EXHIROM_HDR;
			default:           hdr_base = '0;
		endcase
	end

	assign use_hdr = (header_mode == cart_pkg::LOROM) || (header_mode == cart_pkg::HIROM) ||
		(header_mode == cart_pkg::EXHIROM);

	// ========================================
	// Field capture
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
			size_valid <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (cart_wr) begin
				if (ioctl.addr == '0) begin
					size_valid <= 1'b1;
					rom_size   <= cart_pkg::DEF_ROM_SIZE;
					ram_size   <= '0;
					// Size byte from the loader, auto mode only
					if (header_mode == cart_pkg::AUTO && ioctl.data[7:0] != 8'h00) begin
						{ram_size, rom_size} <= ioctl.data[7:0];
					end
					case (header_mode)
						cart_pkg::NO_HEADER, cart_pkg::LOROM: rom_type <= 8'd0;
						cart_pkg::HIROM:                      rom_type <= 8'd1;
						cart_pkg::EXHIROM:                    rom_type <= 8'd2;
						default:                              rom_type <= ioctl.data[15:8];
					endcase
				end
				if (ioctl.addr == 25'd2) begin
					rom_region <= ioctl.data[8];
				end
				if (use_hdr && ioctl.addr == hdr_base + cart_pkg::COPIER_HDR) begin
					rom_size <= ioctl.data[11:8];
				end
				if (use_hdr && ioctl.addr == hdr_base + 25'd2 + cart_pkg::COPIER_HDR) begin
					ram_size <= ioctl.data[3:0];
				end
			end
			// Region is frozen during a cartridge load
			if (!dl_kind.cart) begin
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[0];
			end
		end
	end

	// ========================================
	// Masks
	// ========================================

	always_comb begin
		cart_info.rom_type = rom_type;
		cart_info.ram_size = ram_size;
		cart_info.rom_mask = '0;
		cart_info.ram_mask = '0;
		if (size_valid) begin
			cart_info.rom_mask = (24'd1024 << rom_size) - 24'd1;
			if (ram_size != 4'd0) begin
				cart_info.ram_mask = (24'd1024 << ram_size) - 24'd1;
			end
		end
	end

endmodule

// File: logic/cheat_loader.sv
// Cheat record assembly
`timescale 1ns/100ps

module cheat_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  cart_pkg::ioctl_t      ioctl,
	input  cart_pkg::dl_kind_t    dl_kind,
	input  logic                  cart_start,
	output cart_pkg::cheat_code_t cheat,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic code_wr;

	assign code_wr = dl_kind.code & ioctl.wr;

	// Word placement inside the 16-byte record
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= ioctl.data;
				4'd2:  cheat.flags[31:16]   <= ioctl.data;
				4'd4:  cheat.addr[15:0]     <= ioctl.data;
				4'd6:  cheat.addr[31:16]    <= ioctl.data;
				4'd8:  cheat.compare[15:0]  <= ioctl.data;
				4'd10: cheat.compare[31:16] <= ioctl.data;
				4'd12: cheat.replace[15:0]  <= ioctl.data;
				4'd14: cheat.replace[31:16] <= ioctl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word completes the record
			cheat_valid <= code_wr && ioctl.addr[3:0] == 4'd14;
			// New cheat file or new cartridge drops the old list
			cheat_clear <= (code_wr && ioctl.addr == '0) || cart_start;
		end
	end

	a_valid_single: assert property (
		@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid
	);

endmodule

// File: logic/ram_clear.sv
// Work and audio RAM clearing
`timescale 1ns/100ps

module ram_clear #(
	parameter int FILL_ADDR_W = 18
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_start,
	input  sys_pkg::fill_pattern_e wram_pattern,
	input  sys_pkg::fill_pattern_e aram_pattern,
	output sys_pkg::fill_t        fill,
	output logic                  clearing
);

	logic [FILL_ADDR_W-1:0] addr_cnt;
	logic                   wait_ph;
	logic [17:0]            fill_addr;

	// Power-on byte for one address
	function automatic logic [7:0] pattern_byte(
		input sys_pkg::fill_pattern_e pat,
		input logic [17:0]            a
	);
		logic [7:0] b;
		case (pat)
			sys_pkg::SNES2_9966: b = (a[8] ^ a[2]) ? sys_pkg::BYTE_66 : sys_pkg::BYTE_99;
			sys_pkg::SNES1_00FF: b = (a[9] ^ a[0]) ? sys_pkg::BYTE_FF : 8'h00;
			sys_pkg::FILL_55:    b = sys_pkg::BYTE_55;
			default:             b = sys_pkg::BYTE_FF;
		endcase
		return b;
	endfunction

	// ========================================
	// Sweep control
	// ========================================

	// Write phase then wait phase per address
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing <= 1'b0;
			wait_ph  <= 1'b0;
			addr_cnt <= '0;
		end else if (cart_start) begin
			clearing <= 1'b1;
			wait_ph  <= 1'b0;
			addr_cnt <= '0;
		end else if (clearing) begin
			wait_ph <= ~wait_ph;
			if (wait_ph) begin
				addr_cnt <= addr_cnt + 1'b1;
				// Top address done
				if (&addr_cnt) begin
					clearing <= 1'b0;
				end
			end
		end
	end

	// ========================================
	// Fill outputs
	// ========================================

	assign fill_addr = 18'(addr_cnt);

	always_comb begin
		fill.addr      = fill_addr;
		fill.wram_data = pattern_byte(wram_pattern, fill_addr);
		fill.aram_data = pattern_byte(aram_pattern, fill_addr);
		fill.we        = clearing & ~wait_ph;
	end

	// One strobe per address unless a new load restarts the sweep
	a_we_single: assert property (
		@(posedge clk_sys) disable iff (RESET)
		fill.we && !cart_start |=> !fill.we
	);

endmodule

// File: logic/audio_mix.sv
// Stereo audio mixer
`timescale 1ns/100ps

module audio_mix (
	input  logic             clk_sys,
	input  logic             RESET,
	input  sys_pkg::stereo_t main_audio,
	input  sys_pkg::stereo_t msu_audio,
	output sys_pkg::stereo_t mix_audio
);

	// 17-bit sum, clipped when it leaves the 16-bit range
	function automatic logic signed [15:0] sat_add(
		input logic signed [15:0] a,
		input logic signed [15:0] b
	);
		logic signed [16:0] sum;
		logic signed [15:0] res;
		sum = {a[15], a} + {b[15], b};
		if (sum[16] == sum[15]) begin
			res = sum[15:0];
		end else if (sum[16]) begin
			res = sys_pkg::SAMPLE_MIN;
		end else begin
			res = sys_pkg::SAMPLE_MAX;
		end
		return res;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mix_audio <= '0;
		end else begin
			mix_audio.l <= sat_add(main_audio.l, msu_audio.l);
			mix_audio.r <= sat_add(main_audio.r, msu_audio.r);
		end
	end

endmodule

// File: logic/snes_loader.sv
// Cartridge loader and system support
`timescale 1ns/100ps

module snes_loader #(
	parameter int FILL_ADDR_W = 18
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_pkg::ioctl_t       ioctl,
	input  cart_pkg::header_mode_e header_mode,
	input  logic [1:0]             region_sel,
	input  sys_pkg::fill_pattern_e wram_pattern,
	input  sys_pkg::fill_pattern_e aram_pattern,
	input  sys_pkg::stereo_t       main_audio,
	input  sys_pkg::stereo_t       msu_audio,
	output cart_pkg::cart_info_t   cart_info,
	output logic                   pal,
	output cart_pkg::cheat_code_t  cheat,
	output logic                   cheat_valid,
	output logic                   cheat_clear,
	output sys_pkg::fill_t         fill,
	output logic                   clearing,
	output logic                   core_reset,
	output sys_pkg::stereo_t       mix_audio
);

	cart_pkg::dl_kind_t dl_kind;
	logic               cart_start;

	// ========================================
	// Download side
	// ========================================

	download_decode u_download_decode (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.clearing   (clearing),
		.dl_kind    (dl_kind),
		.cart_start (cart_start),
		.core_reset (core_reset)
	);

	header_detect u_header_detect (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.ioctl       (ioctl),
		.dl_kind     (dl_kind),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.cart_info   (cart_info),
		.pal         (pal)
	);

	cheat_loader u_cheat_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.ioctl       (ioctl),
		.dl_kind     (dl_kind),
		.cart_start  (cart_start),
		.cheat       (cheat),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	// ========================================
	// System side
	// ========================================

	ram_clear #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) u_ram_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_start   (cart_start),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.fill         (fill),
		.clearing     (clearing)
	);

	audio_mix u_audio_mix (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.main_audio (main_audio),
		.msu_audio  (msu_audio),
		.mix_audio  (mix_audio)
	);

endmodule

// File: tests/tb_model.svh
// Loader reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected header fields after one cartridge download
function automatic cart_pkg::cart_info_t ref_cart_info(
	input cart_pkg::header_mode_e mode,
	input logic [15:0]            w0,
	input logic [15:0]            wrom,
	input logic [15:0]            wram
);
	cart_pkg::cart_info_t info;
	int rom_sz;
	int ram_sz;
	rom_sz = int'(cart_pkg::DEF_ROM_SIZE);
	ram_sz = 0;
	case (mode)
		cart_pkg::AUTO: begin
			info.rom_type = w0[15:8];
			if (w0[7:0] != 8'h00) begin
				rom_sz = int'(w0[3:0]);
				ram_sz = int'(w0[7:4]);
			end
		end
		cart_pkg::HIROM:   info.rom_type = 8'd1;
		cart_pkg::EXHIROM: info.rom_type = 8'd2;
		default:           info.rom_type = 8'd0;
	endcase
	// Internal header wins in the forced modes
	if (mode == cart_pkg::LOROM || mode == cart_pkg::HIROM || mode == cart_pkg::EXHIROM) begin
		rom_sz = int'(wrom[11:8]);
		ram_sz = int'(wram[3:0]);
	end
	info.ram_size = 4'(ram_sz);
	info.rom_mask = 24'((longint'(1) << (10 + rom_sz)) - 1);
	info.ram_mask = (ram_sz == 0) ? 24'h0 : 24'((longint'(1) << (10 + ram_sz)) - 1);
	return info;
endfunction

// Power-on byte at one address
function automatic logic [7:0] ref_fill_byte(
	input sys_pkg::fill_pattern_e pat,
	input logic [17:0]            a
);
	case (pat)
		sys_pkg::SNES2_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
		sys_pkg::SNES1_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
		sys_pkg::FILL_55:    return 8'h55;
		default:             return 8'hFF;
	endcase
endfunction

// Record from eight words, low word first
function automatic cart_pkg::cheat_code_t ref_cheat(input logic [15:0] w [8]);
	cart_pkg::cheat_code_t rec;
	rec.flags   = {w[1], w[0]};
	rec.addr    = {w[3], w[2]};
	rec.compare = {w[5], w[4]};
	rec.replace = {w[7], w[6]};
	return rec;
endfunction

// Clipped sum of two samples
function automatic logic [15:0] ref_mix(
	input logic signed [15:0] a,
	input logic signed [15:0] b
);
	int s;
	s = int'(a) + int'(b);
	if (s > 32767) begin
		s = 32767;
	end else if (s < -32768) begin
		s = -32768;
	end
	return 16'(s);
endfunction

`endif

// File: tests/snes_loader_tb.sv
// Loader regression testbench
`timescale 1ns/100ps

module snes_loader_tb;

	localparam int ADDR_W = 10;
	localparam int N_ADDR = 1 << ADDR_W;

	logic                   clk_sys;
	logic                   RESET;
	cart_pkg::ioctl_t       ioctl;
	cart_pkg::header_mode_e header_mode;
	logic [1:0]             region_sel;
	sys_pkg::fill_pattern_e wram_pattern;
	sys_pkg::fill_pattern_e aram_pattern;
	sys_pkg::stereo_t       main_audio;
	sys_pkg::stereo_t       msu_audio;
	cart_pkg::cart_info_t   cart_info;
	logic                   pal;
	cart_pkg::cheat_code_t  cheat;
	logic                   cheat_valid;
	logic                   cheat_clear;
	sys_pkg::fill_t         fill;
	logic                   clearing;
	logic                   core_reset;
	sys_pkg::stereo_t       mix_audio;

	integer seed;
	int     err_cnt;
	int     test_errs;
	int     tests_run;
	int     tests_failed;
	int     seen [N_ADDR];
	int     valid_cnt;
	int     clear_cnt;
	int     audio_cnt;
	logic   audio_on;
	logic   snap_on;
	sys_pkg::stereo_t      snap_main;
	sys_pkg::stereo_t      snap_msu;
	cart_pkg::cheat_code_t exp_cheat_q [$];

	`include "tb_model.svh"

	snes_loader #(
		.FILL_ADDR_W (ADDR_W)
	) uut (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.ioctl        (ioctl),
		.header_mode  (header_mode),
		.region_sel   (region_sel),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.main_audio   (main_audio),
		.msu_audio    (msu_audio),
		.cart_info    (cart_info),
		.pal          (pal),
		.cheat        (cheat),
		.cheat_valid  (cheat_valid),
		.cheat_clear  (cheat_clear),
		.fill         (fill),
		.clearing     (clearing),
		.core_reset   (core_reset),
		.mix_audio    (mix_audio)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		err_cnt++;
		$display("mismatch %s: got %0h expected %0h", name, got, exp);
	endtask

	task automatic report_error(input string msg);
		err_cnt++;
		$display("error: %s", msg);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt == test_errs) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - test_errs);
		end
		test_errs = err_cnt;
	endtask

	// ========================================
	// Checker
	// ========================================

	// Mixer inputs as seen by the register
	always @(posedge clk_sys) begin
		snap_on   = audio_on & ~RESET;
		snap_main = main_audio;
		snap_msu  = msu_audio;
	end

	always @(negedge clk_sys) begin : compare_outputs
		cart_pkg::cheat_code_t exp_rec;
		if (!RESET) begin
			if (fill.we) begin
				if (fill.addr >= 18'(N_ADDR)) begin
					report_error("fill address outside the sweep");
				end else begin
					seen[fill.addr[ADDR_W-1:0]]++;
				end
				if (fill.wram_data !== ref_fill_byte(wram_pattern, fill.addr)) begin
					report_mismatch("fill.wram_data", fill.wram_data,
						ref_fill_byte(wram_pattern, fill.addr));
				end
				if (fill.aram_data !== ref_fill_byte(aram_pattern, fill.addr)) begin
					report_mismatch("fill.aram_data", fill.aram_data,
						ref_fill_byte(aram_pattern, fill.addr));
				end
			end
			if (cheat_valid) begin
				valid_cnt++;
				if (exp_cheat_q.size() == 0) begin
					report_error("cheat_valid pulsed with no record sent");
				end else begin
					exp_rec = exp_cheat_q.pop_front();
					if (cheat !== exp_rec) begin
						report_mismatch("cheat", cheat, exp_rec);
					end
				end
			end
			if (cheat_clear) begin
				clear_cnt++;
			end
			if (snap_on) begin
				audio_cnt++;
				if (mix_audio.l !== ref_mix(snap_main.l, snap_msu.l)) begin
					report_mismatch("mix_audio.l", $unsigned(mix_audio.l),
						ref_mix(snap_main.l, snap_msu.l));
				end
				if (mix_audio.r !== ref_mix(snap_main.r, snap_msu.r)) begin
					report_mismatch("mix_audio.r", $unsigned(mix_audio.r),
						ref_mix(snap_main.r, snap_msu.r));
				end
			end
		end
	end

	// ========================================
	// Bus and wait tasks
	// ========================================

	task automatic begin_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl.index    = index;
		ioctl.download = 1'b1;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl.download = 1'b0;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
	endtask

	task automatic wait_clearing(input logic level, input int limit);
		int n;
		n = 0;
		while (clearing !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (clearing !== level) begin
			report_error($sformatf("timeout waiting for clearing to become %0d", level));
		end
	endtask

	task automatic wait_core_reset(input logic level, input int limit);
		int n;
		n = 0;
		while (core_reset !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset !== level) begin
			report_error($sformatf("timeout waiting for core_reset to become %0d", level));
		end
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_reset_control();
		int n;
		int bad;
		wait_core_reset(1'b0, 8);
		// Cheat file leaves the core running
		begin_download(cart_pkg::IDX_CODE);
		bad = 0;
		repeat (6) begin
			@(negedge clk_sys);
			if (core_reset !== 1'b0) begin
				bad++;
			end
		end
		if (bad != 0) begin
			report_error("core_reset rose during a cheat download");
		end
		end_download();
		begin_download({2'b00, cart_pkg::IDX_SPC});
		wait_core_reset(1'b1, 4);
		end_download();
		wait_core_reset(1'b0, 4);
		// Cartridge holds reset through the whole clear sweep
		begin_download({2'b00, cart_pkg::IDX_CART});
		wait_core_reset(1'b1, 4);
		bad = 0;
		repeat (8) begin
			@(negedge clk_sys);
			if (core_reset !== 1'b1) begin
				bad++;
			end
		end
		end_download();
		n = 0;
		while (clearing && n < 4 * N_ADDR) begin
			if (core_reset !== 1'b1) begin
				bad++;
			end
			@(negedge clk_sys);
			n++;
		end
		if (clearing) begin
			report_error("timeout waiting for the clear sweep to end");
		end
		if (bad != 0) begin
			report_error("core_reset dropped during a cartridge load");
		end
		wait_core_reset(1'b0, 4);
	endtask

	task automatic test_header();
		int pass;
		int rs;
		cart_pkg::header_mode_e mode;
		logic [15:0] w0;
		logic [15:0] w2;
		logic [15:0] wrom;
		logic [15:0] wram;
		logic [24:0] base;
		logic        exp_pal;
		cart_pkg::cart_info_t exp_info;
		for (pass = 0; pass < 6; pass++) begin
			// Extra auto pass without a size byte
			mode = (pass < 5) ? cart_pkg::header_mode_e'(pass) : cart_pkg::AUTO;
			w0   = 16'($random(seed));
			w2   = 16'($random(seed));
			wrom = 16'($random(seed));
			wram = 16'($random(seed));
			if (pass == 5) begin
				w0[7:0] = 8'h00;
			end
			case (mode)
				cart_pkg::HIROM:   base = cart_pkg::HIROM_HDR;
				cart_pkg::EXHIROM: base = cart_pkg::EXHIROM_HDR;
				default:           base = cart_pkg::LOROM_HDR;
			endcase
			@(negedge clk_sys);
			header_mode = mode;
			region_sel  = 2'd0;
			begin_download(pass[0] ? 8'h00 : 8'h41);
			write_word(25'd0, w0);
			write_word(25'd2, w2);
			write_word(base + 25'd512, wrom);
			write_word(base + 25'd514, wram);
			end_download();
			exp_info = ref_cart_info(mode, w0, wrom, wram);
			if (cart_info !== exp_info) begin
				report_mismatch("cart_info", cart_info, exp_info);
			end
			for (rs = 0; rs < 4; rs++) begin
				@(negedge clk_sys);
				region_sel = rs[1:0];
				@(negedge clk_sys);
				exp_pal = (rs == 0) ? w2[8] : rs[0];
				if (pal !== exp_pal) begin
					report_mismatch("pal", pal, exp_pal);
				end
			end
			wait_clearing(1'b0, 4 * N_ADDR);
		end
	endtask

	task automatic test_ram_clear();
		int round;
		int a;
		int n;
		int missing;
		for (round = 0; round < 4; round++) begin
			@(negedge clk_sys);
			wram_pattern = sys_pkg::fill_pattern_e'(2'($random(seed)));
			aram_pattern = sys_pkg::fill_pattern_e'(2'($random(seed)));
			for (a = 0; a < N_ADDR; a++) begin
				seen[a] = 0;
			end
			begin_download({2'b00, cart_pkg::IDX_CART});
			wait_clearing(1'b1, 8);
			n = 0;
			while (clearing && n < 4 * N_ADDR) begin
				@(negedge clk_sys);
				n++;
			end
			if (n != 2 * N_ADDR) begin
				report_mismatch("sweep length", n, 2 * N_ADDR);
			end
			end_download();
			missing = 0;
			for (a = 0; a < N_ADDR; a++) begin
				if (seen[a] != 1) begin
					missing++;
				end
			end
			if (missing != 0) begin
				report_error($sformatf("%0d fill addresses not written exactly once", missing));
			end
		end
	endtask

	task automatic test_cheats();
		logic [15:0] w [8];
		int r;
		int i;
		int n;
		int valid0;
		int clr0;
		valid0 = valid_cnt;
		clr0   = clear_cnt;
		begin_download(cart_pkg::IDX_CODE);
		for (r = 0; r < 6; r++) begin
			for (i = 0; i < 8; i++) begin
				w[i] = 16'($random(seed));
			end
			exp_cheat_q.push_back(ref_cheat(w));
			for (i = 0; i < 8; i++) begin
				write_word(25'(r * 16 + 2 * i), w[i]);
			end
		end
		n = 0;
		while (valid_cnt - valid0 < 6 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		end_download();
		if (valid_cnt - valid0 != 6) begin
			report_mismatch("cheat_valid count", valid_cnt - valid0, 6);
		end
		if (exp_cheat_q.size() != 0) begin
			report_error("cheat record sent but never completed");
		end
		if (clear_cnt - clr0 != 1) begin
			report_mismatch("cheat_clear count", clear_cnt - clr0, 1);
		end
		// New cartridge drops the list
		clr0 = clear_cnt;
		begin_download({2'b00, cart_pkg::IDX_CART});
		wait_clearing(1'b1, 8);
		end_download();
		wait_clearing(1'b0, 4 * N_ADDR);
		if (clear_cnt - clr0 != 1) begin
			report_mismatch("cheat_clear count", clear_cnt - clr0, 1);
		end
	endtask

	task automatic test_audio();
		logic [15:0] ext [6];
		int i;
		int j;
		int n0;
		ext = '{16'h7FFF, 16'h8000, 16'h0001, 16'hFFFF, 16'h0000, 16'h7FFE};
		n0  = audio_cnt;
		for (i = 0; i < 6; i++) begin
			for (j = 0; j < 6; j++) begin
				@(negedge clk_sys);
				audio_on   = 1'b1;
				main_audio = {ext[i], ext[j]};
				msu_audio  = {ext[j], ext[i]};
			end
		end
		for (i = 0; i < 200; i++) begin
			@(negedge clk_sys);
			main_audio = sys_pkg::stereo_t'($random(seed));
			msu_audio  = sys_pkg::stereo_t'($random(seed));
		end
		@(negedge clk_sys);
		audio_on = 1'b0;
		@(negedge clk_sys);
		if (audio_cnt - n0 != 236) begin
			report_mismatch("mixer check count", audio_cnt - n0, 236);
		end
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial begin
		seed         = 32'hd0256d98;
		clk_sys      = 1'b0;
		RESET        = 1'b1;
		ioctl        = '0;
		header_mode  = cart_pkg::AUTO;
		region_sel   = 2'd0;
		wram_pattern = sys_pkg::SNES2_9966;
		aram_pattern = sys_pkg::SNES1_00FF;
		main_audio   = '0;
		msu_audio    = '0;
		audio_on     = 1'b0;
		snap_on      = 1'b0;
		err_cnt      = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		valid_cnt    = 0;
		clear_cnt    = 0;
		audio_cnt    = 0;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;

		test_reset_control();
		finish_test("reset control");
		test_header();
		finish_test("header decode");
		test_ram_clear();
		finish_test("ram clear");
		test_cheats();
		finish_test("cheat records");
		test_audio();
		finish_test("audio mix");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: snes_loader.f
+incdir+tests
logic/cart_pkg.sv
logic/sys_pkg.sv
logic/download_decode.sv
logic/header_detect.sv
logic/cheat_loader.sv
logic/ram_clear.sv
logic/audio_mix.sv
logic/snes_loader.sv
tests/snes_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the loader regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module snes_loader_tb -f snes_loader.f -o snes_loader_sim

./obj_dir/snes_loader_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
exit 1
